// ==== files.f ====
common/grid_pkg.sv
hdl/stream_fifo.sv
hdl/symbol_tagger.sv
hdl/symbol_framer.sv
hdl/grid_subscriber_top.sv
sim/tb_grid_subscriber.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_grid_subscriber
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation ended without result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_grid_subscriber.sv ====
// grid subscriber testbench with clock, lfsr stimulus, reference model, checks and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_grid_subscriber import grid_pkg::*; ();

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYC   = 5;
    // input cycles of all tests together including drains
    localparam int STIM_CYCLES = 2300;
    localparam int WATCHDOG_NS = (STIM_CYCLES * 4 + 500) * 2 * HALF_PERIOD;

    // predicted output beat with bookkeeping flags
    typedef struct packed {
        logic [IQ_WIDTH-1:0] data;
        logic                last;
        logic                hdr;
        logic                sym13;
    } exp_beat_t;

    logic        clk_i;
    logic        reset_ni;
    grid_in_t    s_in_i;
    logic        s_valid_i;
    out_beat_t   m_out_o;
    logic        m_valid_o;
    logic        m_ready_i;
    logic        overflow_o;
    logic        int_o;

    logic [31:0] lfsr_q;
    int          ready_mode;    // 0 ready, 1 random, 2 stalled
    int          sym_seq;
    string       cur_test;
    int          test_errs;
    int          total_errs;
    int          tests_run;

    // reference model
    exp_beat_t   exp_q[$];
    int          samp_cnt;      // samples written and not yet sent
    int          hdr_cnt;       // headers written and not yet sent
    logic        in_sym;
    logic        exp_ovf;
    logic        exp_int;
    logic        prev_reset_n;
    int          drops;
    int          ints_seen;

    grid_subscriber_top dut_i (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .s_in_i     (s_in_i),
        .s_valid_i  (s_valid_i),
        .m_out_o    (m_out_o),
        .m_valid_o  (m_valid_o),
        .m_ready_i  (m_ready_i),
        .overflow_o (overflow_o),
        .int_o      (int_o)
    );

    always #HALF_PERIOD clk_i = ~clk_i;

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            bits   = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL %s %s expected %08h actual %08h", cur_test, what, exp, act);
        test_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR in %s, %s", cur_test, msg);
        test_errs++;
    endtask

    // ready follows the current mode at each falling edge
    task automatic tick();
        @(negedge clk_i);
        case (ready_mode)
            0: m_ready_i = 1'b1;
            1: m_ready_i = (take_bits(2) != 32'd0);
            default: m_ready_i = 1'b0;
        endcase
    endtask

    task automatic apply_reset();
        reset_ni = 1'b0;
        repeat (RESET_CYC) tick();
        reset_ni = 1'b1;
    endtask

    // one symbol with metadata from the running symbol count
    task automatic send_symbol(input int len);
        grid_meta_t meta;
        meta.sfn      = SFN_WIDTH'(sym_seq / (SYM_PER_SF * SUBFRAMES_PER_FRAME));
        meta.subframe = SUBFRAME_WIDTH'((sym_seq / SYM_PER_SF) % SUBFRAMES_PER_FRAME);
        meta.symbol   = SYMBOL_WIDTH'(sym_seq % SYM_PER_SF);
        meta.blk_exp  = BLK_EXP_WIDTH'(take_bits(BLK_EXP_WIDTH));
        sym_seq++;
        for (int i = 0; i < len; i++) begin
            tick();
            s_in_i.data  = take_bits(IQ_WIDTH);
            s_in_i.meta  = meta;
            s_in_i.first = (i == 0);
            s_in_i.last  = (i == len - 1);
            s_valid_i    = 1'b1;
        end
        // one idle cycle between symbols
        tick();
        s_valid_i = 1'b0;
    endtask

    // wait until every predicted beat has left
    task automatic drain();
        while (exp_q.size() != 0) begin
            tick();
        end
        repeat (3) tick();
    endtask

    task automatic start_test(input string name, input int mode);
        cur_test   = name;
        ready_mode = mode;
    endtask

    task automatic finish_test();
        $display("%-14s %s, %0d errors", cur_test, (test_errs == 0) ? "passed" : "failed",
                 test_errs);
        total_errs += test_errs;
        test_errs   = 0;
        tests_run++;
    endtask

    // a stalled beat holds still
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        $past(m_valid_o && !m_ready_i) |-> (m_valid_o && $stable(m_out_o)))
        else report_problem("output beat changed while the DMA stalled");

    always @(posedge clk_i) begin : model
        exp_beat_t   head;
        logic        room;
        logic        is13;
        logic [31:0] hdr_word;
        // reset at the previous edge keeps all outputs low
        if (!prev_reset_n) begin
            assert (!m_valid_o && !overflow_o && !int_o)
                else report_problem("valid or status output high during reset");
        end
        prev_reset_n = reset_ni;
        if (!reset_ni) begin
            exp_q.delete();
            samp_cnt = 0;
            hdr_cnt  = 0;
            in_sym   = 1'b0;
            exp_ovf  = 1'b0;
            exp_int  = 1'b0;
        end else begin
            // pulses predicted one edge earlier
            assert (overflow_o == exp_ovf)
                else report_mismatch("overflow_o", 32'(exp_ovf), 32'(overflow_o));
            assert (int_o == exp_int)
                else report_mismatch("int_o", 32'(exp_int), 32'(int_o));
            ints_seen += int'(int_o);
            drops     += int'(overflow_o);
            exp_ovf = 1'b0;
            exp_int = 1'b0;
            head    = '0;
            if (exp_q.size() != 0) begin
                head = exp_q[0];
            end
            // the beat in the output register has already left its fifo
            room = (SAMPLE_FIFO_DEPTH - samp_cnt + int'(m_valid_o && !head.hdr) >= MAX_SYM_LEN)
                && (hdr_cnt - int'(m_valid_o && head.hdr) < HEADER_FIFO_DEPTH);
            if (m_valid_o && m_ready_i) begin
                if (exp_q.size() == 0) begin
                    report_problem("beat sent while no beat was expected");
                end else begin
                    head = exp_q.pop_front();
                    assert (m_out_o.data == head.data)
                        else report_mismatch("data", head.data, m_out_o.data);
                    assert (m_out_o.last == head.last)
                        else report_mismatch("last", 32'(head.last), 32'(m_out_o.last));
                    samp_cnt -= int'(!head.hdr);
                    hdr_cnt  -= int'(head.hdr);
                    exp_int   = head.last && head.sym13;
                end
            end
            if (s_valid_i) begin
                is13 = (s_in_i.meta.symbol == SYMBOL_WIDTH'(SYM_PER_SF - 1));
                if (s_in_i.first) begin
                    exp_ovf = !room;
                    in_sym  = room;
                    // blk_exp 7..0, symbol 11..8, subframe 16..12, sfn 26..17
                    hdr_word = (32'(s_in_i.meta.sfn) << 17) | (32'(s_in_i.meta.subframe) << 12)
                             | (32'(s_in_i.meta.symbol) << 8) | 32'(s_in_i.meta.blk_exp);
                    if (room) begin
                        exp_q.push_back(exp_beat_t'{hdr_word, 1'b0, 1'b1, is13});
                        hdr_cnt++;
                    end
                end
                if (in_sym) begin
                    exp_q.push_back(exp_beat_t'{s_in_i.data, s_in_i.last, 1'b0, is13});
                    samp_cnt++;
                end
                if (s_in_i.last) begin
                    in_sym = 1'b0;
                end
            end
        end
    end

    initial begin
        clk_i        = 1'b0;
        reset_ni     = 1'b0;
        s_in_i       = '0;
        s_valid_i    = 1'b0;
        m_ready_i    = 1'b0;
        lfsr_q       = 32'h054767ee;
        prev_reset_n = 1'b1;
        // start at sfn 517, symbol 10
        sym_seq      = 517 * SYM_PER_SF * SUBFRAMES_PER_FRAME + 10;
        start_test("power_on_reset", 0);
        apply_reset();
        finish_test();

        start_test("packet_format", 0);
        repeat (6) send_symbol(1 + int'(take_bits(3)));
        drain();
        finish_test();

        start_test("back_pressure", 1);
        repeat (10) send_symbol(1 + int'(take_bits(4)));
        drain();
        finish_test();

        // long symbols against a stalled DMA fill both fifos
        start_test("symbol_drop", 2);
        drops = 0;
        repeat (24) send_symbol(32 + int'(take_bits(5)));
        ready_mode = 0;
        drain();
        assert (drops > 0) else report_problem("no symbol was dropped");
        repeat (4) send_symbol(8 + int'(take_bits(4)));
        drain();
        finish_test();

        start_test("interrupt", 1);
        ints_seen = 0;
        repeat (30) send_symbol(1 + int'(take_bits(2)));
        drain();
        assert (ints_seen >= 2) else report_problem("too few subframe interrupts seen");
        finish_test();

        // reset with packets still buffered and then one clean packet
        start_test("reset", 2);
        repeat (3) send_symbol(4 + int'(take_bits(3)));
        apply_reset();
        ready_mode = 0;
        send_symbol(8);
        drain();
        finish_test();

        $display("%0d tests run, %0d errors", tests_run, total_errs);
        if (total_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests completed");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/grid_subscriber_top.sv ====
// top level with tagger, sample and header fifos and framer
`timescale 1ns/1ns
`default_nettype none

module grid_subscriber_top import grid_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     reset_ni,

    // demodulator side
    input  wire grid_in_t s_in_i,
    input  wire logic     s_valid_i,

    // dma side
    output out_beat_t     m_out_o,
    output logic          m_valid_o,
    input  wire logic     m_ready_i,

    // status
    output logic          overflow_o,
    output logic          int_o
);

    // sample path
    logic                       samp_wr;
    sample_t                    samp_wdata;
    sample_t                    samp_rdata;
    logic                       samp_rvalid;
    logic                       samp_pop;
    logic [SAMP_FREE_WIDTH-1:0] samp_free;

    // header path
    logic                       hdr_wr;
    grid_meta_t                 hdr_wdata;
    grid_meta_t                 hdr_rdata;
    logic                       hdr_rvalid;
    logic                       hdr_pop;
    logic                       hdr_full;

    symbol_tagger tagger_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .s_in_i      (s_in_i),
        .s_valid_i   (s_valid_i),
        .samp_free_i (samp_free),
        .hdr_full_i  (hdr_full),
        .samp_wr_o   (samp_wr),
        .samp_data_o (samp_wdata),
        .hdr_wr_o    (hdr_wr),
        .hdr_data_o  (hdr_wdata),
        .overflow_o  (overflow_o)
    );

    // sample buffer whose free count feeds admission
    stream_fifo #(
        .DEPTH     (SAMPLE_FIFO_DEPTH),
        .payload_t (sample_t)
    ) sample_fifo_i (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_en_i    (samp_wr),
        .wr_data_i  (samp_wdata),
        .rd_en_i    (samp_pop),
        .rd_data_o  (samp_rdata),
        .rd_valid_o (samp_rvalid),
        .free_o     (samp_free),
        .full_o     ()
    );

    // one metadata entry per admitted symbol
    stream_fifo #(
        .DEPTH     (HEADER_FIFO_DEPTH),
        .payload_t (grid_meta_t)
    ) header_fifo_i (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_en_i    (hdr_wr),
        .wr_data_i  (hdr_wdata),
        .rd_en_i    (hdr_pop),
        .rd_data_o  (hdr_rdata),
        .rd_valid_o (hdr_rvalid),
        .free_o     (),
        .full_o     (hdr_full)
    );

    symbol_framer framer_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .hdr_i        (hdr_rdata),
        .hdr_valid_i  (hdr_rvalid),
        .hdr_pop_o    (hdr_pop),
        .samp_i       (samp_rdata),
        .samp_valid_i (samp_rvalid),
        .samp_pop_o   (samp_pop),
        .m_out_o      (m_out_o),
        .m_valid_o    (m_valid_o),
        .m_ready_i    (m_ready_i),
        .int_o        (int_o)
    );

endmodule

`default_nettype wire

// ==== hdl/symbol_framer.sv ====
// header plus sample packet builder and subframe interrupt
`timescale 1ns/1ns
`default_nettype none

module symbol_framer import grid_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       reset_ni,

    // header fifo read side
    input  wire grid_meta_t hdr_i,
    input  wire logic       hdr_valid_i,
    output logic            hdr_pop_o,

    // sample fifo read side
    input  wire sample_t    samp_i,
    input  wire logic       samp_valid_i,
    output logic            samp_pop_o,

    // dma stream
    output out_beat_t       m_out_o,
    output logic            m_valid_o,
    input  wire logic       m_ready_i,

    // end of subframe
    output logic            int_o
);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        SAMPLES
    } state_t;

    state_t    state_q;

    // registered output beat
    out_beat_t out_q;
    logic      valid_q;

    // packet in flight carries the last symbol of its subframe
    logic      last_sym_q;
    logic      int_q;

    logic      out_free;
    logic      beat_done;
    out_beat_t hdr_beat;

    // output register can take a new beat this cycle
    assign out_free  = !valid_q || m_ready_i;
    assign beat_done = valid_q && m_ready_i;

    // a new packet starts only from idle
    assign hdr_pop_o  = (state_q == IDLE) && hdr_valid_i && out_free;
    // samples follow once the header is in the output register
    assign samp_pop_o = (state_q != IDLE) && samp_valid_i && out_free;

    // header word is the metadata zero extended to the sample width
    assign hdr_beat.data = {HDR_PAD_WIDTH'(0), hdr_i};
    assign hdr_beat.last = 1'b0;

    // output beat payload
    always_ff @(posedge clk_i) begin
        if (hdr_pop_o) begin
            out_q <= hdr_beat;
        end else if (samp_pop_o) begin
            out_q.data <= samp_i.data;
            out_q.last <= samp_i.last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= IDLE;
            valid_q    <= 1'b0;
            last_sym_q <= 1'b0;
            int_q      <= 1'b0;
        end else begin
            // interrupt one cycle after the last beat of symbol 13 leaves
            int_q <= beat_done && out_q.last && last_sym_q;

            // hold while stalled and drop valid once the beat has gone
            if (hdr_pop_o || samp_pop_o) begin
                valid_q <= 1'b1;
            end else if (m_ready_i) begin
                valid_q <= 1'b0;
            end

            case (state_q)
                IDLE: begin
                    if (hdr_pop_o) begin
                        state_q    <= HEADER;
                        last_sym_q <= (hdr_i.symbol == SYMBOL_WIDTH'(SYM_PER_SF - 1));
                    end
                end
                // header waits in the output register or samples stream on
                // and both forward samples until last
                HEADER, SAMPLES: begin
                    if (samp_pop_o) begin
                        state_q <= samp_i.last ? IDLE : SAMPLES;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign m_out_o   = out_q;
    assign m_valid_o = valid_q;
    assign int_o     = int_q;

endmodule

`default_nettype wire

// ==== hdl/symbol_tagger.sv ====
// whole-symbol admission, fifo writes and overflow pulse
`timescale 1ns/1ns
`default_nettype none

module symbol_tagger import grid_pkg::*; (
    input  wire logic                       clk_i,
    input  wire logic                       reset_ni,

    // demodulator stream that cannot stall
    input  wire grid_in_t                   s_in_i,
    input  wire logic                       s_valid_i,

    // fifo fill levels
    input  wire logic [SAMP_FREE_WIDTH-1:0] samp_free_i,
    input  wire logic                       hdr_full_i,

    // sample fifo write
    output logic                            samp_wr_o,
    output sample_t                         samp_data_o,

    // header fifo write with one entry per symbol
    output logic                            hdr_wr_o,
    output grid_meta_t                      hdr_data_o,

    // one pulse per dropped symbol
    output logic                            overflow_o
);

    // current symbol was admitted so its tail beats go to the fifo
    logic admitted_q;
    logic overflow_q;

    logic first_beat;
    logic room;
    logic admit;

    assign first_beat = s_valid_i && s_in_i.first;

    // reserve room for the longest symbol since the length is not known up front
    assign room = (samp_free_i >= SAMP_FREE_WIDTH'(MAX_SYM_LEN)) && !hdr_full_i;

    // decision only on a first beat
    assign admit = first_beat && room;

    // samples go in when the symbol starts admitted or is already admitted;
    // a first beat always decides afresh
    assign samp_wr_o = s_valid_i && (s_in_i.first ? room : admitted_q);

    assign samp_data_o.data = s_in_i.data;
    assign samp_data_o.last = s_in_i.last;

    // header entry goes in together with the first sample
    assign hdr_wr_o   = admit;
    assign hdr_data_o = s_in_i.meta;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            admitted_q <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            // single beat symbols never open the admitted state
            if (first_beat) begin
                admitted_q <= room && !s_in_i.last;
            end else if (s_valid_i && s_in_i.last) begin
                admitted_q <= 1'b0;
            end
            // rejected first beat pulses on the following cycle
            overflow_q <= first_beat && !room;
        end
    end

    assign overflow_o = overflow_q;

endmodule

`default_nettype wire

// ==== hdl/stream_fifo.sv ====
// synchronous show-ahead fifo with typed payload and free count
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [7:0]
) (
    input  wire logic                       clk_i,
    input  wire logic                       reset_ni,

    // write side without back-pressure
    input  wire logic                       wr_en_i,
    input  wire payload_t                   wr_data_i,

    // read side with the head entry held in a register
    input  wire logic                       rd_en_i,
    output payload_t                        rd_data_o,
    output logic                            rd_valid_o,

    // occupancy for admission decisions
    output logic [$clog2(DEPTH + 1) - 1:0]  free_o,
    output logic                            full_o
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    payload_t             mem_q [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_q;

    // entries held in total including the output register
    logic [CNT_WIDTH-1:0] used_q;
    // entries still in the array and not yet in the output register
    logic [CNT_WIDTH-1:0] mem_cnt;

    payload_t             rd_data_q;
    logic                 rd_valid_q;

    logic                 push;
    logic                 pop;
    logic                 load;

    // writes into a full fifo are lost
    assign push = wr_en_i && (used_q != CNT_WIDTH'(DEPTH));
    assign pop  = rd_en_i && rd_valid_q;

    assign mem_cnt = used_q - CNT_WIDTH'(rd_valid_q);

    // refill the head register when it is empty or being popped
    assign load = (mem_cnt != '0) && (!rd_valid_q || pop);

    // array write
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

    // head register runs one cycle behind the array
    always_ff @(posedge clk_i) begin
        if (load) begin
            rd_data_q <= mem_q[rd_ptr_q];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            used_q     <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (load) begin
                rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // head stays valid until popped with nothing behind it
            rd_valid_q <= load || (rd_valid_q && !pop);
            if (push && !pop) begin
                used_q <= used_q + 1'b1;
            end else if (pop && !push) begin
                used_q <= used_q - 1'b1;
            end
        end
    end

    assign rd_data_o  = rd_data_q;
    assign rd_valid_o = rd_valid_q;
    assign free_o     = CNT_WIDTH'(DEPTH) - used_q;
    assign full_o     = (used_q == CNT_WIDTH'(DEPTH));

endmodule

`default_nettype wire

// ==== common/grid_pkg.sv ====
// grid constants, metadata field widths and stream beat structs
`default_nettype none

package grid_pkg;

    // NR frame structure
    localparam int SFN_MAX             = 1023;
    localparam int SUBFRAMES_PER_FRAME = 20;
    localparam int SYM_PER_SF          = 14;

    // metadata field widths, derived from the frame structure
    localparam int SFN_WIDTH      = $clog2(SFN_MAX + 1);
    localparam int SUBFRAME_WIDTH = $clog2(SUBFRAMES_PER_FRAME);
    localparam int SYMBOL_WIDTH   = $clog2(SYM_PER_SF);
    localparam int BLK_EXP_WIDTH  = 8;
    localparam int META_WIDTH     = SFN_WIDTH + SUBFRAME_WIDTH + SYMBOL_WIDTH + BLK_EXP_WIDTH;

    // one complex sample, 16 bit I and 16 bit Q
    localparam int IQ_WIDTH = 32;

    // zero bits above the metadata in the header word
    localparam int HDR_PAD_WIDTH = IQ_WIDTH - META_WIDTH;

    // test symbol length limit, admission reserves this much space
    localparam int MAX_SYM_LEN = 64;

    // buffer sizes
    localparam int SAMPLE_FIFO_DEPTH = 256;
    localparam int HEADER_FIFO_DEPTH = 8;
    localparam int SAMP_FREE_WIDTH   = $clog2(SAMPLE_FIFO_DEPTH + 1);

    // field order puts blk_exp in the lsbs and sfn on top,
    // which is the header word layout
    typedef struct packed {
        logic [SFN_WIDTH-1:0]      sfn;
        logic [SUBFRAME_WIDTH-1:0] subframe;
        logic [SYMBOL_WIDTH-1:0]   symbol;
        logic [BLK_EXP_WIDTH-1:0]  blk_exp;
    } grid_meta_t;

    // input beat from the demodulator
    typedef struct packed {
        logic [IQ_WIDTH-1:0] data;
        grid_meta_t          meta;
        logic                first;
        logic                last;
    } grid_in_t;

    // sample fifo entry
    typedef struct packed {
        logic [IQ_WIDTH-1:0] data;
        logic                last;
    } sample_t;

    // beat towards the dma
    typedef struct packed {
        logic [IQ_WIDTH-1:0] data;
        logic                last;
    } out_beat_t;

endpackage

`default_nettype wire
